// ==== design/ulaTimingPkg.sv ====
package ulaTimingPkg;

  ////////////////////////////////////////
  // Sequencer types
  ////////////////////////////////////////
  typedef logic [23:0] slotT;   // One-hot ring, one slot per CLK_24 cycle
  typedef logic [2:0]  phaseT;  // One-hot memory phase
  typedef logic [6:0]  hCountT; // Column, 1 us each
  typedef logic [8:0]  vCountT; // Line, 64 us each

  // Phase bit positions
  localparam int PH_VIDEO1 = 0;
  localparam int PH_VIDEO2 = 1;
  localparam int PH_CPU    = 2;  // Also PHI2

  // Slot strobes
  localparam int SLOT_PH1_LOAD = 23; // Last slot of the CPU phase
  localparam int SLOT_PH2_LOAD = 7;
  localparam int SLOT_CPU_LOAD = 15; // Also the 1 MHz enable
  localparam int SLOT_ATTR     = 3;  // Attribute flag sampled from DB
  localparam int SLOT_BUS_A    = 2;  // Phase 1 byte latched
  localparam int SLOT_BUS_B    = 10; // Phase 2 byte latched
  localparam int SLOT_RELOAD   = 17; // Shifter and attribute update
  localparam int SLOT_WRITE    = 17; // CPU write strobe

  // Pixel slots 1, 5, 9, 13, 17, 21
  localparam slotT PIX_SLOT_MASK = 24'h222222;

  ////////////////////////////////////////
  // Line and column limits
  ////////////////////////////////////////
  localparam hCountT H_LAST       = 7'd63;
  localparam hCountT H_SYNC_FIRST = 7'd49;
  localparam hCountT H_SYNC_LAST  = 7'd53;
  localparam hCountT H_VIS_FIRST  = 7'd1;
  localparam hCountT H_VIS_LAST   = 7'd40;
  localparam hCountT H_RELOAD     = 7'd49; // Attributes restored from here on

  localparam vCountT V_LAST_50     = 9'd312; // 313 lines
  localparam vCountT V_LAST_60     = 9'd260; // 261 lines
  localparam vCountT V_SYNC50      = 9'd258;
  localparam vCountT V_SYNC60      = 9'd241;
  localparam int     V_SYNC_LINES  = 2;
  localparam vCountT V_BLANK_FIRST = 9'd224;
  localparam vCountT V_TEXT_FORCE  = 9'd199; // Text forced below this line

endpackage

// ==== design/ulaVideoPkg.sv ====
package ulaVideoPkg;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////
  typedef logic [15:0] addrT;  // CPU and SRAM address
  typedef logic [7:0]  dataT;  // Data bus byte
  typedef logic [2:0]  colorT; // Bit 0 red, bit 1 green, bit 2 blue

  // Attribute selector, byte bits 6..3
  typedef enum logic [3:0] {
    ATTR_INK   = 4'd0,
    ATTR_STYLE = 4'd1,
    ATTR_PAPER = 4'd2,
    ATTR_MODE  = 4'd3
  } attrSelT;

  ////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////
  localparam addrT TEXT_BASE  = 16'hBB80; // 40x28 text screen
  localparam addrT HIRES_BASE = 16'hA000; // 240x200 bitmap

  // Character set prefixes, address bits 15..10
  localparam logic [5:0] CHAR_BASE_TEXT_STD  = 6'b101101; // xB4xx
  localparam logic [5:0] CHAR_BASE_TEXT_ALT  = 6'b101110; // xB8xx
  localparam logic [5:0] CHAR_BASE_HIRES_STD = 6'b100110; // x98xx
  localparam logic [5:0] CHAR_BASE_HIRES_ALT = 6'b100111; // x9Cxx

  localparam logic [7:0] IO_PAGE = 8'h03; // x0300..x03FF

  ////////////////////////////////////////
  // Attribute register bits
  ////////////////////////////////////////
  localparam int MODE_FREQ_BIT  = 1; // 1 = 50 Hz
  localparam int MODE_HIRES_BIT = 2; // 1 = hires
  localparam int STYLE_ALT_BIT  = 0; // 1 = alternate charset

endpackage

// ==== design/ulaSequencer.sv ====
`timescale 1ns/100ps
module ulaSequencer
  import ulaTimingPkg::*;
(
  input  logic  CLK_24,
  input  logic  RESET_INT,
  output slotT  slot,     // One-hot, 24 slots per microsecond
  output phaseT phase,    // Video 1, video 2, CPU
  output logic  cpuEn,    // 1 MHz enable, one cycle wide
  output logic  PHI2,
  output logic  CLK_PIX   // Six pixel strobes per microsecond
);

  logic phaseEnd; // Last slot of the current phase

  assign phaseEnd = slot[SLOT_PH2_LOAD] | slot[SLOT_CPU_LOAD] | slot[SLOT_PH1_LOAD];

  ////////////////////////////////////////
  // Slot ring and phase rotation
  ////////////////////////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      slot  <= slotT'(1);   // Slot 0
      phase <= phaseT'(1);  // Video phase 1
    end else begin
      slot <= {slot[22:0], slot[23]};
      if (phaseEnd) begin
        phase <= {phase[1:0], phase[2]};  // Every 8 slots
      end
    end
  end

  // CPU runs in the third phase
  assign PHI2  = phase[PH_CPU];
  assign cpuEn = slot[SLOT_CPU_LOAD];  // Just before PHI2 rises

  // Pixel clock, every fourth slot from slot 1
  assign CLK_PIX = |(slot & PIX_SLOT_MASK);

endmodule

// ==== design/ulaBusDecode.sv ====
`timescale 1ns/100ps
module ulaBusDecode
  import ulaTimingPkg::*, ulaVideoPkg::*;
(
  input  addrT  ADDR,
  input  logic  MAPn,
  input  logic  RW,
  input  slotT  slot,
  input  phaseT phase,
  output logic  CSIOn,
  output logic  CSROMn,
  output logic  CSRAMn,
  output logic  SRAM_OE,
  output logic  SRAM_CE,
  output logic  SRAM_WE,
  output logic  LATCH_SRAM
);

  // Latch pulses at slots 4, 12 and 20
  localparam slotT LATCH_SLOT_MASK = 24'h101010;

  logic cpuPhase;
  logic videoPhase;
  logic ioPage;   // x03xx
  logic romArea;  // xC000 and up
  logic ramSel;

  assign cpuPhase   = phase[PH_CPU];
  assign videoPhase = phase[PH_VIDEO1] | phase[PH_VIDEO2];
  assign ioPage     = (ADDR[15:8] == IO_PAGE);
  assign romArea    = &ADDR[15:14];

  ////////////////////////////////////////
  // Chip selects, CPU phase only
  ////////////////////////////////////////
  assign CSIOn  = ~(cpuPhase & ioPage);
  assign CSROMn = ~(cpuPhase & romArea & MAPn);

  // Shadow RAM under ROM, or ordinary RAM outside the I/O page
  assign ramSel = cpuPhase & ((romArea & ~MAPn) | (~romArea & ~ioPage));
  assign CSRAMn = ~ramSel;

  // SRAM strobes
  assign SRAM_OE = videoPhase | (cpuPhase & RW);  // Video always reads
  assign SRAM_CE = videoPhase | ramSel;
  assign SRAM_WE = ramSel & ~RW & slot[SLOT_WRITE]; // Single-slot write pulse

  assign LATCH_SRAM = ~|(slot & LATCH_SLOT_MASK); // Active low

endmodule

// ==== design/ulaVideoTiming.sv ====
`timescale 1ns/100ps
module ulaVideoTiming
  import ulaTimingPkg::*;
#(
  parameter vCountT vLast50 = V_LAST_50,
  parameter vCountT vLast60 = V_LAST_60
) (
  input  logic   CLK_24,
  input  logic   RESET_INT,
  input  logic   cpuEn,
  input  logic   freqSel,    // 1 = 50 Hz
  output hCountT hCount,
  output vCountT vCount,
  output logic   HSYNC,      // Active low
  output logic   VSYNC,      // Active low
  output logic   SYNC,
  output logic   blankingN,
  output logic   hReload,
  output logic   forceText
);

  vCountT vLast;     // Last line of the selected frame
  vCountT vSyncFirst;
  logic   hVisible;
  logic   vVisible;

  assign vLast      = freqSel ? vLast50 : vLast60;
  assign vSyncFirst = freqSel ? V_SYNC50 : V_SYNC60;

  ////////////////////////////////////////
  // Counters, one step per microsecond
  ////////////////////////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      hCount <= '0;
      vCount <= '0;
    end else if (cpuEn) begin
      if (hCount == H_LAST) begin
        hCount <= '0;
        // >= covers a switch from 50 to 60 Hz late in the frame
        if (vCount >= vLast) begin
          vCount <= '0;
        end else begin
          vCount <= vCount + 1'b1;
        end
      end else begin
        hCount <= hCount + 1'b1;
      end
    end
  end

  // Sync
  assign HSYNC = ~((hCount >= H_SYNC_FIRST) && (hCount <= H_SYNC_LAST));
  assign VSYNC = ~((vCount >= vSyncFirst) && (vCount < vSyncFirst + V_SYNC_LINES));
  assign SYNC  = ~(HSYNC ^ VSYNC);  // Composite

  // Visible area, 40 columns by 224 lines
  assign hVisible  = (hCount >= H_VIS_FIRST) && (hCount <= H_VIS_LAST);
  assign vVisible  = (vCount < V_BLANK_FIRST);
  assign blankingN = hVisible & vVisible;

  assign hReload   = (hCount >= H_RELOAD);     // Attribute restore window
  assign forceText = (vCount > V_TEXT_FORCE);  // Bottom three text rows

endmodule

// ==== design/ulaAttrDecoder.sv ====
`timescale 1ns/100ps
module ulaAttrDecoder
  import ulaTimingPkg::*, ulaVideoPkg::*;
(
  input  logic CLK_24,
  input  logic RESET_INT,
  input  slotT slot,
  input  dataT DB,
  input  logic hReload,
  input  logic blankingN,
  input  logic forceText,
  output dataT dataLatch,
  output logic hiresMode,
  output logic altSel,
  output logic freqSel,
  output logic R,
  output logic G,
  output logic B
);

  localparam int    SLOT_HOLD_HIRES = 5;  // Phase 1 byte is the bitmap
  localparam int    SLOT_HOLD_ATTR  = 9;  // Before slot 10 overwrites the latch
  localparam int    SLOT_HOLD_TEXT  = 12; // Glyph row from phase 2
  localparam colorT INK_RELOAD      = 3'b111;

  logic       isAttrib;  // Current cell is an attribute
  logic       invHold;
  logic       invPix;
  logic       loadHold;
  logic [6:0] regHold;   // Selector and value, or pixel bits
  logic [5:0] shifter;
  logic [2:0] style;     // Flash and double height bits kept, unused
  logic [2:0] mode;
  colorT      ink;
  colorT      paper;
  colorT      pixColor;
  colorT      outColor;

  ////////////////////////////////////////
  // Bus capture
  ////////////////////////////////////////
  always_ff @(posedge CLK_24) begin
    if (slot[SLOT_BUS_A] || slot[SLOT_BUS_B]) begin
      dataLatch <= DB;
    end
  end

  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      isAttrib <= 1'b0;
      invHold  <= 1'b0;
    end else if (slot[SLOT_ATTR]) begin
      isAttrib <= ~|DB[6:5];  // Bits 6 and 5 clear
      invHold  <= DB[7];
    end
  end

  assign loadHold = isAttrib ? slot[SLOT_HOLD_ATTR] :
                    (hiresMode ? slot[SLOT_HOLD_HIRES] : slot[SLOT_HOLD_TEXT]);

  always_ff @(posedge CLK_24) begin
    if (loadHold) begin
      regHold <= dataLatch[6:0];
    end
  end

  ////////////////////////////////////////
  // Attribute registers
  ////////////////////////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      ink   <= INK_RELOAD;
      style <= '0;
      paper <= '0;
      mode  <= '0;
    end else if (hReload) begin
      ink   <= INK_RELOAD;  // Mode survives the line end
      style <= '0;
      paper <= '0;
    end else if (slot[SLOT_RELOAD] && isAttrib && blankingN) begin
      case (attrSelT'(regHold[6:3]))
        ATTR_INK:   ink   <= regHold[2:0];
        ATTR_STYLE: style <= regHold[2:0];
        ATTR_PAPER: paper <= regHold[2:0];
        ATTR_MODE:  mode  <= regHold[2:0];
        default:    ;  // Codes 4..15 ignored
      endcase
    end
  end

  assign altSel    = style[STYLE_ALT_BIT];
  assign freqSel   = mode[MODE_FREQ_BIT];
  assign hiresMode = mode[MODE_HIRES_BIT] & ~forceText;

  // Pixel shifter, MSB first, attribute cells shift in paper
  always_ff @(posedge CLK_24) begin
    if (|(slot & PIX_SLOT_MASK)) begin
      if (slot[SLOT_RELOAD] && !isAttrib) begin
        shifter <= regHold[5:0];
      end else begin
        shifter <= {shifter[4:0], 1'b0};
      end
    end
  end

  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      invPix <= 1'b0;
    end else if (slot[SLOT_RELOAD]) begin
      invPix <= invHold;  // Aligned with the shifter load
    end
  end

  // Colour out
  assign pixColor = shifter[5] ? ink : paper;
  assign outColor = invPix ? ~pixColor : pixColor;
  assign R = outColor[0];
  assign G = outColor[1];
  assign B = outColor[2];

endmodule

// ==== design/ulaVideoAddr.sv ====
`timescale 1ns/100ps
module ulaVideoAddr
  import ulaTimingPkg::*, ulaVideoPkg::*;
(
  input  logic   CLK_24,
  input  slotT   slot,
  input  addrT   ADDR,
  input  hCountT hCount,
  input  vCountT vCount,
  input  dataT   dataLatch,
  input  logic   hiresMode,
  input  logic   altSel,
  output addrT   SRAM_AD
);

  vCountT     row;        // Screen row
  addrT       rowX40;
  addrT       screenBase;
  addrT       vap1;       // Screen byte
  addrT       vap2;       // Glyph row
  logic [5:0] charBase;
  addrT       adReg = '0; // Zero until the first phase 1 load

  ////////////////////////////////////////
  // Phase 1, screen memory
  ////////////////////////////////////////
  assign row        = hiresMode ? vCount : (vCount >> 3);  // 8 lines per text row
  assign rowX40     = ({7'd0, row} << 5) + ({7'd0, row} << 3); // 32 + 8
  assign screenBase = hiresMode ? HIRES_BASE : TEXT_BASE;
  assign vap1       = screenBase + rowX40 + {9'd0, hCount};

  // Phase 2, character set
  always_comb begin
    case ({hiresMode, altSel})
      2'b11:   charBase = CHAR_BASE_HIRES_ALT;
      2'b10:   charBase = CHAR_BASE_HIRES_STD;
      2'b01:   charBase = CHAR_BASE_TEXT_ALT;
      default: charBase = CHAR_BASE_TEXT_STD;
    endcase
  end

  assign vap2 = {charBase, dataLatch[6:0], vCount[2:0]};

  // Address mux, loaded one slot ahead of each phase
  always_ff @(posedge CLK_24) begin
    if (slot[SLOT_PH1_LOAD]) begin
      adReg <= vap1;
    end else if (slot[SLOT_PH2_LOAD]) begin
      adReg <= vap2;
    end else if (slot[SLOT_CPU_LOAD]) begin
      adReg <= ADDR;  // CPU address held through PHI2
    end
  end

  assign SRAM_AD = adReg;

endmodule

// ==== design/ulaTop.sv ====
`timescale 1ns/100ps
module ulaTop
  import ulaTimingPkg::*, ulaVideoPkg::*;
(
  input  logic CLK_24,
  input  logic RESET_INT,
  input  logic RW,         // CPU read/write
  input  logic MAPn,       // Low maps shadow RAM over ROM
  input  dataT DB,
  input  addrT ADDR,
  output logic PHI2,       // 1 MHz CPU clock
  output logic PHI2_EN,
  output logic CSRAMn,
  output logic CSIOn,
  output logic CSROMn,
  output addrT SRAM_AD,
  output logic SRAM_OE,
  output logic SRAM_CE,
  output logic SRAM_WE,
  output logic LATCH_SRAM,
  output logic R,
  output logic G,
  output logic B,
  output logic SYNC,       // Composite sync
  output logic HSYNC,
  output logic VSYNC,
  output logic CLK_PIX
);

  slotT   slot;
  phaseT  phase;
  hCountT hCount;
  vCountT vCount;
  logic   hReload;
  logic   blankingN;
  logic   forceText;
  logic   freqSel;    // From mode register
  logic   hiresMode;
  logic   altSel;
  dataT   dataLatch;  // Last byte read from SRAM

  ulaSequencer uSequencer (
    .CLK_24    (CLK_24),
    .RESET_INT (RESET_INT),
    .slot      (slot),
    .phase     (phase),
    .cpuEn     (PHI2_EN),
    .PHI2      (PHI2),
    .CLK_PIX   (CLK_PIX)
  );

  ulaBusDecode uBusDecode (
    .ADDR       (ADDR),
    .MAPn       (MAPn),
    .RW         (RW),
    .slot       (slot),
    .phase      (phase),
    .CSIOn      (CSIOn),
    .CSROMn     (CSROMn),
    .CSRAMn     (CSRAMn),
    .SRAM_OE    (SRAM_OE),
    .SRAM_CE    (SRAM_CE),
    .SRAM_WE    (SRAM_WE),
    .LATCH_SRAM (LATCH_SRAM)
  );

  ulaVideoTiming #(
    .vLast50 (V_LAST_50),
    .vLast60 (V_LAST_60)
  ) uVideoTiming (
    .CLK_24    (CLK_24),
    .RESET_INT (RESET_INT),
    .cpuEn     (PHI2_EN),
    .freqSel   (freqSel),
    .hCount    (hCount),
    .vCount    (vCount),
    .HSYNC     (HSYNC),
    .VSYNC     (VSYNC),
    .SYNC      (SYNC),
    .blankingN (blankingN),
    .hReload   (hReload),
    .forceText (forceText)
  );

  ulaAttrDecoder uAttrDecoder (
    .CLK_24    (CLK_24),
    .RESET_INT (RESET_INT),
    .slot      (slot),
    .DB        (DB),
    .hReload   (hReload),
    .blankingN (blankingN),
    .forceText (forceText),
    .dataLatch (dataLatch),
    .hiresMode (hiresMode),
    .altSel    (altSel),
    .freqSel   (freqSel),
    .R         (R),
    .G         (G),
    .B         (B)
  );

  ulaVideoAddr uVideoAddr (
    .CLK_24    (CLK_24),
    .slot      (slot),
    .ADDR      (ADDR),
    .hCount    (hCount),
    .vCount    (vCount),
    .dataLatch (dataLatch),
    .hiresMode (hiresMode),
    .altSel    (altSel),
    .SRAM_AD   (SRAM_AD)
  );

endmodule

// ==== dv/ulaTb_assert.sv ====
`timescale 1ns/100ps
module ulaBusAssert (
  input logic CLK_24,
  input logic RESET_INT,
  input logic PHI2,
  input logic RW,
  input logic CSRAMn,
  input logic CSIOn,
  input logic CSROMn,
  input logic SRAM_WE
);

  logic [2:0] selN;  // Active-low selects
  int         failCount = 0;

  assign selN = {CSRAMn, CSIOn, CSROMn};

  ////////////////////////////////////////
  // Bus selects and write strobe
  ////////////////////////////////////////
  assert property (@(posedge CLK_24) disable iff (RESET_INT) $onehot0(~selN))
    else begin
      $error("More than one chip select is low");
      failCount++;
    end

  // Selects only while the CPU owns the bus
  assert property (@(posedge CLK_24) disable iff (RESET_INT) !PHI2 |-> (&selN))
    else begin
      $error("A chip select is low outside PHI2");
      failCount++;
    end

  // Write only on a CPU write cycle
  assert property (@(posedge CLK_24) disable iff (RESET_INT) SRAM_WE |-> !RW && PHI2)
    else begin
      $error("SRAM_WE is high outside a CPU write");
      failCount++;
    end

  assert property (@(posedge CLK_24) disable iff (RESET_INT) SRAM_WE |=> !SRAM_WE)
    else begin
      $error("SRAM_WE is high for more than one slot");
      failCount++;
    end

endmodule

bind ulaTop ulaBusAssert uBusAssert (
  .CLK_24    (CLK_24),
  .RESET_INT (RESET_INT),
  .PHI2      (PHI2),
  .RW        (RW),
  .CSRAMn    (CSRAMn),
  .CSIOn     (CSIOn),
  .CSROMn    (CSROMn),
  .SRAM_WE   (SRAM_WE)
);

// ==== dv/ulaTb.sv ====
`timescale 1ns/100ps
module ulaTb
  import ulaVideoPkg::*;
();

  localparam int LINE_CYCLES = 64 * 24;  // 64 us per line

  logic CLK_24;
  logic RESET_INT;
  logic RW;
  logic MAPn;
  dataT DB;
  addrT ADDR;
  addrT SRAM_AD;
  logic PHI2, PHI2_EN, CLK_PIX;
  logic CSRAMn, CSIOn, CSROMn;
  logic SRAM_OE, SRAM_CE, SRAM_WE, LATCH_SRAM;
  logic R, G, B, SYNC, HSYNC, VSYNC;

  dataT dbByte;    // Byte the SRAM returns
  int   tbSlot;    // Reference position since reset
  int   tbCol;
  int   tbLine;    // No wrap, video tests stay in frame 0
  int   errCount;

  ulaTop i_dut (.*);

  assign DB = dbByte;  // Every address holds the same byte

  initial begin
    CLK_24 = 1'b0;
    forever #50 CLK_24 = ~CLK_24;  // 10 MHz stand-in for 24 MHz
  end

  ////////////////////////////////////////
  // Reference slot, column and line
  ////////////////////////////////////////
  always @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      tbSlot <= 0;
      tbCol  <= 0;
      tbLine <= 0;
    end else begin
      tbSlot <= (tbSlot == 23) ? 0 : tbSlot + 1;
      if (tbSlot == 15) begin  // Step at the end of phase 2
        if (tbCol == 63) begin
          tbCol  <= 0;
          tbLine <= tbLine + 1;
        end else begin
          tbCol <= tbCol + 1;
        end
      end
    end
  end

  task automatic stopRun(input string msg);
    errCount++;
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stopRun($sformatf("ERROR %s: expected %h, got %h", name, exp, got));
  endtask

  // Bound bus checker failures end the run too
  always @(negedge CLK_24) begin
    assert (i_dut.uBusAssert.failCount == 0)
      else stopRun("A bound bus assertion failed");
  end

  task automatic applyReset(input dataT b);
    @(posedge CLK_24);
    RESET_INT <= 1'b1;
    dbByte    <= b;
    repeat (16) @(posedge CLK_24);
    RESET_INT <= 1'b0;
  endtask

  task automatic waitSlot(input int s);
    int guard;
    guard = 0;
    @(negedge CLK_24);
    while (tbSlot != s) begin
      guard++;
      assert (guard <= 30)
        else stopRun($sformatf("Timeout while waiting for slot %0d", s));
      @(negedge CLK_24);
    end
  endtask

  // Counts negedges until the sync output reaches level
  task automatic waitSyncLevel(input bit vertical, input logic level, input int limit,
                               output int cycles);
    cycles = 0;
    do begin
      @(negedge CLK_24);
      cycles++;
      assert (cycles <= limit)
        else stopRun(vertical ? "Timeout while waiting for VSYNC"
                              : "Timeout while waiting for HSYNC");
    end while ((vertical ? VSYNC : HSYNC) !== level);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic decodeTest;
    addrT a;
    logic m, io, rom, ram;
    for (int i = 0; i < 30; i++) begin
      a = addrT'($urandom);
      if (i % 5 == 0) begin
        a[15:8] = 8'h03;  // Hit the I/O page now and then
      end
      m = $urandom % 2;
      waitSlot(0);
      @(posedge CLK_24);
      ADDR <= a;
      MAPn <= m;
      waitSlot(20);  // Middle of the CPU phase
      io  = (a[15:8] == 8'h03);
      rom = (a >= 16'hC000) && m;
      ram = ((a >= 16'hC000) && !m) || ((a < 16'hC000) && !io);
      checkValue("CSIOn", CSIOn, !io);
      checkValue("CSROMn", CSROMn, !rom);
      checkValue("CSRAMn", CSRAMn, !ram);
    end
  endtask

  task automatic writeCheck(input addrT a, input logic m, input logic expWe);
    waitSlot(0);
    @(posedge CLK_24);
    ADDR <= a;
    MAPn <= m;
    RW   <= 1'b0;
    waitSlot(17);
    checkValue("SRAM_WE", SRAM_WE, expWe);
    @(posedge CLK_24);
    RW <= 1'b1;
  endtask

  task automatic cpuPathTest;
    addrT a;
    for (int i = 0; i < 10; i++) begin
      a = addrT'($urandom);
      waitSlot(0);
      @(posedge CLK_24);
      ADDR <= a;
      waitSlot(20);
      checkValue("SRAM_AD", SRAM_AD, a);  // Captured in slot 15
    end
    writeCheck(16'h0400 + addrT'($urandom % 32'hB000), 1'b1, 1'b1);  // Plain RAM
    writeCheck(16'hC000 | addrT'($urandom), 1'b1, 1'b0);            // ROM
  endtask

  // One microsecond of clocks and strobes, slot by slot
  task automatic strobeTest(input addrT a, input logic m, input logic rw, input logic ramHit);
    waitSlot(23);
    @(posedge CLK_24);
    ADDR <= a;
    MAPn <= m;
    RW   <= rw;
    for (int s = 0; s < 24; s++) begin
      waitSlot(s);
      checkValue("PHI2", PHI2, s >= 16);
      checkValue("PHI2_EN", PHI2_EN, s == 15);
      checkValue("CLK_PIX", CLK_PIX, s % 4 == 1);
      checkValue("LATCH_SRAM", LATCH_SRAM, s % 8 != 4);
      checkValue("SRAM_OE", SRAM_OE, s < 16 || rw);      // Video phases always read
      checkValue("SRAM_CE", SRAM_CE, s < 16 || ramHit);
    end
    @(posedge CLK_24);
    RW <= 1'b1;
  endtask

  task automatic textAddrTest;
    addrT expAddr;
    applyReset(8'h40);
    while (tbLine < 16) begin
      waitSlot(3);
      expAddr = TEXT_BASE + addrT'(40 * (tbLine / 8)) + addrT'(tbCol);
      if (tbLine != 0 || tbCol != 0) begin  // Nothing loaded yet in the first us
        checkValue("SRAM_AD", SRAM_AD, expAddr);
      end
    end
  endtask

  task automatic lineTimingTest;
    int n, lowLen, highLen;
    waitSyncLevel(1'b0, 1'b1, 2 * LINE_CYCLES, n);
    waitSyncLevel(1'b0, 1'b0, 2 * LINE_CYCLES, n);  // First falling edge
    checkValue("SYNC", SYNC, 1'b0);                  // Follows HSYNC outside VSYNC
    waitSyncLevel(1'b0, 1'b1, 2 * LINE_CYCLES, lowLen);
    checkValue("SYNC", SYNC, 1'b1);
    waitSyncLevel(1'b0, 1'b0, 2 * LINE_CYCLES, highLen);
    checkValue("HSYNC low cycles", lowLen, 5 * 24);
    checkValue("HSYNC period", lowLen + highLen, LINE_CYCLES);
  endtask

  task automatic frameRateTest(input dataT b, input int lines);
    int n, lowLen, highLen;
    applyReset(b);
    waitSyncLevel(1'b1, 1'b1, 400 * LINE_CYCLES, n);
    waitSyncLevel(1'b1, 1'b0, 400 * LINE_CYCLES, n);
    checkValue("SYNC", SYNC, 1'b0);  // VSYNC low, HSYNC high at column 0
    waitSyncLevel(1'b1, 1'b1, 400 * LINE_CYCLES, lowLen);
    waitSyncLevel(1'b1, 1'b0, 400 * LINE_CYCLES, highLen);
    checkValue("VSYNC low cycles", lowLen, 2 * LINE_CYCLES);  // Two lines
    checkValue("VSYNC period", lowLen + highLen, lines * LINE_CYCLES);
  endtask

  task automatic pixelTest(input dataT b, input logic expLevel);
    int guard;
    applyReset(b);
    guard = 0;
    while (!(tbLine == 10 && tbCol == 5)) begin
      @(negedge CLK_24);
      guard++;
      assert (guard <= 12 * LINE_CYCLES)
        else stopRun("Timeout while waiting for line 10");
    end
    while (tbLine == 10 && tbCol <= 35) begin
      if (tbSlot % 4 == 1) begin  // Pixel slots
        checkValue("R", R, expLevel);
        checkValue("G", G, expLevel);
        checkValue("B", B, expLevel);
      end
      @(negedge CLK_24);
    end
  endtask

  initial begin
    RESET_INT = 1'b1;
    RW        = 1'b1;
    MAPn      = 1'b1;
    ADDR      = '0;
    dbByte    = '0;
    errCount  = 0;
    void'($urandom(32'hc85e2a53));
    applyReset(8'h00);
    waitSlot(3);
    checkValue("SRAM_AD", SRAM_AD, 16'h0000);  // Before the first slot 23
    decodeTest();
    cpuPathTest();
    strobeTest(16'h1234, 1'b1, 1'b1, 1'b1);  // RAM read
    strobeTest(16'hE000, 1'b1, 1'b0, 1'b0);  // ROM write
    textAddrTest();
    lineTimingTest();
    frameRateTest(8'h00, 261);  // Mode 0, 60 Hz
    frameRateTest(8'h1A, 313);  // Mode attribute, 50 Hz
    pixelTest(8'h7F, 1'b1);
    pixelTest(8'hFF, 1'b0);     // Inverse video
    if (errCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== ulaTop.f ====
design/ulaTimingPkg.sv
design/ulaVideoPkg.sv
design/ulaSequencer.sv
design/ulaBusDecode.sv
design/ulaVideoTiming.sv
design/ulaAttrDecoder.sv
design/ulaVideoAddr.sv
design/ulaTop.sv
dv/ulaTb_assert.sv
dv/ulaTb.sv
